/* codec_init_table.svh */
// register writes sent to the codec after start, in table order
// the core clock is enabled first because the codec ignores other writes
// until its clock is running
// after that come the serial port, converter, mixer and power settings,
// and the clock enables for the blocks come last

localparam int INIT_LEN = 11;

localparam codec_word_pkg::host_write_t INIT_TABLE [INIT_LEN] = '{
   // turn on the core clock
   '{reg_addr: 16'h4000, reg_data: 8'h01},
   // serial port 0 runs as the clock master
   '{reg_addr: 16'h4015, reg_data: 8'h01},
   // serial port 1 keeps default framing
   '{reg_addr: 16'h4016, reg_data: 8'h00},
   // converter 0 keeps the default sample rate
   '{reg_addr: 16'h4017, reg_data: 8'h00},
   // enable both ADC channels
   '{reg_addr: 16'h4019, reg_data: 8'h03},
   // route the left DAC into the left playback mixer
   '{reg_addr: 16'h401c, reg_data: 8'h21},
   // route the right DAC into the right playback mixer
   '{reg_addr: 16'h401e, reg_data: 8'h41},
   // power up the playback path
   '{reg_addr: 16'h4029, reg_data: 8'h03},
   // enable both DAC channels
   '{reg_addr: 16'h402a, reg_data: 8'h03},
   // enable the clocks of all digital blocks
   '{reg_addr: 16'h40f9, reg_data: 8'h7f},
   '{reg_addr: 16'h40fa, reg_data: 8'h03}
};

/* codec_word_pkg.sv */
`default_nettype none

// definitions for the 32-bit control word sent to the codec
// the word goes out MSB first, so the chip byte leads, then the subaddress, then the data
package codec_word_pkg;

   // the codec answers to chip address zero in its serial control mode
   localparam logic [6:0] CHIP_ADDR = 7'h00;

   // the lowest bit of the chip byte selects the direction and zero means write
   localparam logic RW_WRITE = 1'b0;

   // first byte of every word this block sends
   localparam logic [7:0] CHIP_ADDR_WRITE = {CHIP_ADDR, RW_WRITE};

   // field view of one control word, listed from the MSB down
   typedef struct packed {
      logic [7:0]  chip_addr_rw;
      logic [15:0] reg_addr;
      logic [7:0]  reg_data;
   } ctrl_fields_t;

   // the same 32 bits are either filled in by field or shifted out as a plain word
   typedef union packed {
      ctrl_fields_t fields;
      logic [31:0]  raw;
   } ctrl_word_t;

   // a register write as the host gives it
   // the chip byte is added by the sequencer
   typedef struct packed {
      logic [15:0] reg_addr;
      logic [7:0]  reg_data;
   } host_write_t;

endpackage

`default_nettype wire

/* spi_link_pkg.sv */
`default_nettype none

// definitions for the serial control link to the codec
package spi_link_pkg;

   // pins driven by the serial master
   // clatch_n frames a transfer and cdata changes while cclk is low
   typedef struct packed {
      logic cdata;
      logic cclk;
      logic clatch_n;
   } spi_pins_t;

   // width of the master state counter
   localparam int STATE_BITS = 7;

   // a transfer walks two states per bit, low half first and then high half
   // so bit 31 uses states 0 and 1 and bit 0 uses states 62 and 63
   // cclk is high in the odd states

   // state 63 is the high half of the last bit
   // clatch_n goes high when the master leaves it
   localparam logic [STATE_BITS-1:0] LATCH_RISE = 7'd63;

   // one more divided half period with clatch_n high keeps the latch pulse wide enough
   localparam logic [STATE_BITS-1:0] LATCH_WAIT = 7'd64;

   // the master only takes a new word here
   // this state is odd, so the master has to hold cclk low in it explicitly
   localparam logic [STATE_BITS-1:0] IDLE = 7'd65;

endpackage

`default_nettype wire

/* codec_init_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

// producer of control words for the command FIFO
// after a start pulse it sends every entry of the init table once, in order
// after that it passes host register writes straight through
module codec_init_sequencer (
   input  wire                              clk,
   input  wire                              reset,
   input  wire                              start,

   input  wire                              host_valid,
   input  wire codec_word_pkg::host_write_t host_cmd,
   output logic                             host_ready,

   output logic                             seq_valid,
   output codec_word_pkg::ctrl_word_t       seq_word,
   input  wire                              seq_ready,

   output logic                             init_done
);

   `include "codec_init_table.svh"

   // the table index only has to reach INIT_LEN - 1
   localparam int IDX_BITS = (INIT_LEN > 1) ? $clog2(INIT_LEN) : 1;
   localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(INIT_LEN - 1);

   // FSM states
   // idle waits for start, walk sends the table, host forwards host writes
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_WALK = 2'd1;
   localparam logic [1:0] ST_HOST = 2'd2;

   logic [1:0]                  state;
   logic [IDX_BITS-1:0]         idx;
   codec_word_pkg::host_write_t entry;
   logic                        accept;

   // the host state is only reached after the last table entry was taken,
   // so it doubles as the done flag and stays until reset
   assign init_done = (state == ST_HOST);

   // host writes pass through in the same cycle
   // before init is done the host is held off
   assign host_ready = init_done && seq_ready;

   // in the walk state a table entry is always on offer
   // in the host state the host decides
   assign seq_valid = (state == ST_WALK) || ((state == ST_HOST) && host_valid);

   assign accept = seq_valid && seq_ready;

   // pick the register write to send
   // idx only moves on an accepted word, so the table entry stays stable
   // for as long as it is offered
   always_comb begin
      if (state == ST_HOST) begin
         entry = host_cmd;
      end else begin
         entry = INIT_TABLE[idx];
      end

      // build the word by field, the chip byte always carries the write bit
      seq_word.fields.chip_addr_rw = codec_word_pkg::CHIP_ADDR_WRITE;
      seq_word.fields.reg_addr     = entry.reg_addr;
      seq_word.fields.reg_data     = entry.reg_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               // the first entry goes out on the cycle after start
               if (start) begin
                  state <= ST_WALK;
                  idx   <= '0;
               end
            end
            ST_WALK: begin
               if (accept) begin
                  // after the last entry the host gets the FIFO
                  if (idx == LAST_IDX) begin
                     state <= ST_HOST;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            ST_HOST: begin
               // only reset leaves this state, so a later start does nothing
               state <= ST_HOST;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* cmd_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

// synchronous FIFO of control words between the sequencer and the serial master
// FIFO_DEPTH has to be a power of two and at least two
module cmd_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  wire                             clk,
   input  wire                             reset,

   input  wire                             in_valid,
   input  wire codec_word_pkg::ctrl_word_t in_word,
   output logic                            in_ready,

   output logic                            out_valid,
   output codec_word_pkg::ctrl_word_t      out_word,
   input  wire                             out_ready,

   output logic                            empty
);

   localparam int IDX_BITS = $clog2(FIFO_DEPTH);

   codec_word_pkg::ctrl_word_t mem [FIFO_DEPTH];

   // the pointers carry one wrap bit above the index
   // equal pointers mean empty
   // pointers that differ only in the wrap bit mean full
   logic [IDX_BITS:0] wr_ptr;
   logic [IDX_BITS:0] rd_ptr;
   logic              full;
   logic              push;
   logic              pop;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[IDX_BITS] != rd_ptr[IDX_BITS]) &&
                  (wr_ptr[IDX_BITS-1:0] == rd_ptr[IDX_BITS-1:0]);

   // a word written on one edge shows up as valid right after that edge
   assign out_valid = !empty;

   // when full, a pop in the same cycle frees the slot that is written
   assign in_ready = !full || out_ready;

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   // the head word is read straight from the storage registers, never bypassed
   assign out_word = mem[rd_ptr[IDX_BITS-1:0]];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[IDX_BITS-1:0]] <= in_word;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* spi_ctrl_master.sv */
`timescale 1ns/1ns
`default_nettype none

// serial master for the codec control port
// one 32-bit word goes out per transfer, MSB first, framed by clatch_n low
// every state lasts CCLK_DIVIDER system clocks, which is one half period of cclk
module spi_ctrl_master #(
   parameter int CCLK_DIVIDER = 6
) (
   input  wire                             clk,
   input  wire                             reset,

   input  wire codec_word_pkg::ctrl_word_t word,
   input  wire                             valid,
   output logic                            ready,

   output spi_link_pkg::spi_pins_t         spi
);

   // the divider counts 0 to CCLK_DIVIDER - 1 and ticks on the last count
   localparam int DIV_BITS = (CCLK_DIVIDER > 1) ? $clog2(CCLK_DIVIDER) : 1;
   localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(CCLK_DIVIDER - 1);

   logic [spi_link_pkg::STATE_BITS-1:0] state;
   logic [DIV_BITS-1:0]                 divider;
   logic                                div_tick;
   logic [31:0]                         shift_reg;
   logic                                clatch_n;
   logic                                cclk;

   assign div_tick = (divider == DIV_LAST);

   // a new word is only taken while idle
   assign ready = (state == spi_link_pkg::IDLE);

   // cclk follows the low state bit
   // IDLE is odd, so it is forced low there, or a short idle could leave
   // a high pulse shorter than one half period
   assign cclk = state[0] && !ready;

   // the MSB of the shift register drives the data pin
   assign spi = '{cdata: shift_reg[31], cclk: cclk, clatch_n: clatch_n};

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= spi_link_pkg::IDLE;
         divider   <= '0;
         clatch_n  <= 1'b1;
         shift_reg <= '0;
      end else if (ready) begin
         // accepting a word starts state 0 with a fresh divider and opens the frame
         if (valid) begin
            state     <= '0;
            divider   <= '0;
            clatch_n  <= 1'b0;
            shift_reg <= word.raw;
         end
      end else begin
         if (div_tick) begin
            divider <= '0;
         end else begin
            divider <= divider + 1'b1;
         end

         if (div_tick) begin
            // after the latch wait the master goes back to idle
            if (state == spi_link_pkg::LATCH_WAIT) begin
               state <= spi_link_pkg::IDLE;
            end else begin
               state <= state + 1'b1;
            end

            // the codec samples on the rising edge, so the next bit is
            // moved up when cclk is about to fall
            if (cclk) begin
               shift_reg <= {shift_reg[30:0], 1'b0};
            end

            // the frame closes as the last high half ends
            if (state == spi_link_pkg::LATCH_RISE) begin
               clatch_n <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* codec_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

// control port of the codec configuration block
// the sequencer feeds the command FIFO and the serial master drains it
module codec_ctrl_top #(
   parameter int CCLK_DIVIDER = 6,
   parameter int FIFO_DEPTH   = 8
) (
   input  wire                              clk,
   input  wire                              reset,
   input  wire                              start,

   input  wire                              host_valid,
   input  wire codec_word_pkg::host_write_t host_cmd,
   output logic                             host_ready,

   output logic                             init_done,
   output logic                             busy,

   output spi_link_pkg::spi_pins_t          spi
);

   logic                       seq_valid;
   logic                       seq_ready;
   codec_word_pkg::ctrl_word_t seq_word;
   logic                       out_valid;
   logic                       out_ready;
   codec_word_pkg::ctrl_word_t out_word;
   logic                       fifo_empty;
   logic                       walking;

   codec_init_sequencer u_sequencer (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .host_valid (host_valid),
      .host_cmd   (host_cmd),
      .host_ready (host_ready),
      .seq_valid  (seq_valid),
      .seq_word   (seq_word),
      .seq_ready  (seq_ready),
      .init_done  (init_done)
   );

   cmd_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (seq_valid),
      .in_word   (seq_word),
      .in_ready  (seq_ready),
      .out_valid (out_valid),
      .out_word  (out_word),
      .out_ready (out_ready),
      .empty     (fifo_empty)
   );

   spi_ctrl_master #(
      .CCLK_DIVIDER (CCLK_DIVIDER)
   ) u_master (
      .clk   (clk),
      .reset (reset),
      .word  (out_word),
      .valid (out_valid),
      .ready (out_ready),
      .spi   (spi)
   );

   // before init is done the sequencer only offers words while it walks the table
   assign walking = seq_valid && !init_done;

   // the block is busy while any stage still holds or makes a word
   assign busy = walking || !fifo_empty || !out_ready;

endmodule

`default_nettype wire

/* spi_slave_model.sv */
`timescale 1ns/1ns
`default_nettype none

// pin level model of the codec control port
// it shifts cdata in on every rising cclk while clatch_n is low and hands out the word
// when clatch_n rises, together with the widths it measured during that frame
// all widths are counted in system clocks
module spi_slave_model (
   input  wire                          clk,
   input  wire                          reset,
   input  wire spi_link_pkg::spi_pins_t spi,

   output logic                         word_valid,
   output logic [31:0]                  word,
   output logic [5:0]                   bit_count,
   output logic [15:0]                  high_min,
   output logic [15:0]                  high_max,
   output logic [15:0]                  latch_gap
);

   logic        prev_cclk;
   logic        prev_latch_n;
   logic [31:0] shift;
   logic [5:0]  bits;
   logic [15:0] high_cnt;
   logic [15:0] high_lo;
   logic [15:0] high_hi;
   logic [15:0] gap_cnt;
   logic [15:0] gap_at_fall;
   logic        cclk_fall;
   logic [15:0] high_lo_next;
   logic [15:0] high_hi_next;

   // the last cclk fall and the latch rise land on the same edge,
   // so the pulse that ends there is folded in before the frame is reported
   assign cclk_fall    = prev_cclk && !spi.cclk;
   assign high_lo_next = (cclk_fall && (high_cnt < high_lo)) ? high_cnt : high_lo;
   assign high_hi_next = (cclk_fall && (high_cnt > high_hi)) ? high_cnt : high_hi;

   always_ff @(posedge clk) begin
      if (reset) begin
         prev_cclk    <= 1'b0;
         prev_latch_n <= 1'b1;
         shift        <= '0;
         bits         <= '0;
         high_cnt     <= '0;
         high_lo      <= '1;
         high_hi      <= '0;
         // the time before the first frame counts as a long idle
         gap_cnt      <= '1;
         gap_at_fall  <= '0;
         word_valid   <= 1'b0;
         word         <= '0;
         bit_count    <= '0;
         high_min     <= '0;
         high_max     <= '0;
         latch_gap    <= '0;
      end else begin
         word_valid   <= 1'b0;
         prev_cclk    <= spi.cclk;
         prev_latch_n <= spi.clatch_n;
         high_lo      <= high_lo_next;
         high_hi      <= high_hi_next;

         // length of the current cclk high pulse
         if (spi.cclk) begin
            high_cnt <= high_cnt + 1'b1;
         end else begin
            high_cnt <= '0;
         end

         // length of the latch high time
         // it stops at its top value after a long idle
         if (!spi.clatch_n) begin
            gap_cnt <= '0;
         end else if (gap_cnt != 16'hffff) begin
            gap_cnt <= gap_cnt + 1'b1;
         end

         // a falling latch opens a new frame
         if (prev_latch_n && !spi.clatch_n) begin
            gap_at_fall <= gap_cnt;
            bits        <= '0;
            high_lo     <= '1;
            high_hi     <= '0;
         end

         // the codec takes a data bit on every rising cclk inside the frame
         if (!prev_cclk && spi.cclk && !spi.clatch_n) begin
            shift <= {shift[30:0], spi.cdata};
            bits  <= bits + 1'b1;
         end

         // a rising latch ends the frame
         if (!prev_latch_n && spi.clatch_n) begin
            word_valid <= 1'b1;
            word       <= shift;
            bit_count  <= bits;
            high_min   <= high_lo_next;
            high_max   <= high_hi_next;
            latch_gap  <= gap_at_fall;
         end
      end
   end

endmodule

`default_nettype wire

/* tb_codec_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

// testbench for the codec control port
// the init table plus six host writes form the list of expected words,
// and a pin level model of the codec decodes what the serial master sends
module tb_codec_ctrl;

   `include "codec_init_table.svh"

   localparam int CCLK_DIVIDER = 6;
   // a shallow FIFO lets a short host burst run into back-pressure
   localparam int FIFO_DEPTH   = 2;
   localparam int HOST_LEN     = 6;
   localparam int TOTAL_LEN    = INIT_LEN + HOST_LEN;
   // one transfer with some margin in system clocks
   localparam int WORD_CYCLES  = 70 * CCLK_DIVIDER;
   localparam int LONG_LIMIT   = (TOTAL_LEN + 2) * WORD_CYCLES;

   // one host write and how it is offered
   // early means right after start
   // burst means no idle cycle before it
   typedef struct packed {
      codec_word_pkg::host_write_t cmd;
      logic                        early;
      logic                        burst;
   } host_step_t;

   localparam host_step_t HOST_STEPS [HOST_LEN] = '{
      '{cmd: '{reg_addr: 16'h4020, reg_data: 8'h05}, early: 1'b1, burst: 1'b0},
      '{cmd: '{reg_addr: 16'h4023, reg_data: 8'he7}, early: 1'b0, burst: 1'b0},
      '{cmd: '{reg_addr: 16'h4024, reg_data: 8'h5a}, early: 1'b0, burst: 1'b0},
      '{cmd: '{reg_addr: 16'h4025, reg_data: 8'ha5}, early: 1'b0, burst: 1'b1},
      '{cmd: '{reg_addr: 16'h4026, reg_data: 8'hff}, early: 1'b0, burst: 1'b1},
      '{cmd: '{reg_addr: 16'h40c0, reg_data: 8'h00}, early: 1'b0, burst: 1'b1}
   };

   logic                        clk = 1'b0;
   logic                        reset;
   logic                        start;
   logic                        host_valid;
   codec_word_pkg::host_write_t host_cmd;
   logic                        host_ready;
   logic                        init_done;
   logic                        busy;
   spi_link_pkg::spi_pins_t     spi;

   logic                        rx_valid;
   logic [31:0]                 rx_word;
   logic [5:0]                  rx_bits;
   logic [15:0]                 rx_high_min;
   logic [15:0]                 rx_high_max;
   logic [15:0]                 rx_gap;

   codec_word_pkg::host_write_t exp_cmd [TOTAL_LEN];
   int                          rx_count;
   int                          error_count;
   int                          init_errors;
   int                          host_errors;
   int                          timing_errors;
   int                          failed_tests;
   logic                        held_seen;
   logic                        stall_seen;
   logic                        accept_done;

   always #4 clk = ~clk;

   codec_ctrl_top #(
      .CCLK_DIVIDER (CCLK_DIVIDER),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) u_codec_ctrl_top (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .host_valid (host_valid),
      .host_cmd   (host_cmd),
      .host_ready (host_ready),
      .init_done  (init_done),
      .busy       (busy),
      .spi        (spi)
   );

   spi_slave_model u_codec_model (
      .clk        (clk),
      .reset      (reset),
      .spi        (spi),
      .word_valid (rx_valid),
      .word       (rx_word),
      .bit_count  (rx_bits),
      .high_min   (rx_high_min),
      .high_max   (rx_high_max),
      .latch_gap  (rx_gap)
   );

   // every decoded word is checked field by field against the expected list
   always @(posedge clk) begin
      if (!reset && rx_valid) begin
         if (rx_count >= TOTAL_LEN) begin
            $display("[ERROR] %0t: unexpected extra word %h", $time, rx_word);
            error_count++;
         end else if ((rx_word[31:24] != codec_word_pkg::CHIP_ADDR_WRITE) ||
                      (rx_word[23:8] != exp_cmd[rx_count].reg_addr) ||
                      (rx_word[7:0] != exp_cmd[rx_count].reg_data) || (rx_bits != 6'd32)) begin
            $display("[ERROR] %0t: word %0d expected %h %h %h, got %h with %0d bits", $time,
                     rx_count, codec_word_pkg::CHIP_ADDR_WRITE, exp_cmd[rx_count].reg_addr,
                     exp_cmd[rx_count].reg_data, rx_word, rx_bits);
            error_count++;
            if (rx_count < INIT_LEN) begin
               init_errors++;
            end else begin
               host_errors++;
            end
         end
         // every high pulse is one divided half period and the latch gap at least one
         if ((rx_high_min != CCLK_DIVIDER) || (rx_high_max != CCLK_DIVIDER) ||
             (rx_gap < CCLK_DIVIDER)) begin
            $display("[ERROR] %0t: word %0d cclk high %0d to %0d, latch gap %0d", $time,
                     rx_count, rx_high_min, rx_high_max, rx_gap);
            error_count++;
            timing_errors++;
         end
         rx_count++;
      end
   end

   task automatic stop_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("STATUS: FAIL");
      $finish;
   endtask

   task automatic report_test(input int num, input string name, input logic ok);
      $display("test %0d %s: %s", num, name, ok ? "ok" : "failed");
      if (!ok) begin
         failed_tests++;
      end
   endtask

   task automatic wait_words(input int n, input string what);
      int cycles;
      cycles = 0;
      while ((rx_count < n) && (cycles < LONG_LIMIT)) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (rx_count < n) begin
         stop_on_timeout(what);
      end
   endtask

   // offers one host write and returns just after the edge that took it
   // host_valid stays high so the next write can follow with no gap
   task automatic send_host(input codec_word_pkg::host_write_t cmd, input logic in_burst);
      int cycles;
      host_valid = 1'b1;
      host_cmd   = cmd;
      cycles     = 0;
      while (!host_ready && (cycles < LONG_LIMIT)) begin
         if (!init_done) begin
            held_seen = 1'b1;
         end
         if (in_burst) begin
            stall_seen = 1'b1;
         end
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!host_ready) begin
         stop_on_timeout("host_ready");
      end
      accept_done = init_done;
      @(posedge clk);
      #1;
   endtask

   initial begin
      int seed_value;
      int cycles;
      logic first_done;
      logic busy_seen;
      seed_value    = $urandom(32'hb1bb_0945);
      reset         = 1'b1;
      start         = 1'b0;
      host_valid    = 1'b0;
      host_cmd      = '0;
      rx_count      = 0;
      error_count   = 0;
      init_errors   = 0;
      host_errors   = 0;
      timing_errors = 0;
      failed_tests  = 0;
      held_seen     = 1'b0;
      stall_seen    = 1'b0;
      accept_done   = 1'b0;
      first_done    = 1'b0;
      busy_seen     = 1'b0;

      // the expected words are the init table followed by the host writes
      for (int i = 0; i < TOTAL_LEN; i++) begin
         if (i < INIT_LEN) begin
            exp_cmd[i] = INIT_TABLE[i];
         end else begin
            exp_cmd[i] = HOST_STEPS[i - INIT_LEN].cmd;
         end
      end

      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;

      // test 1 checks the idle outputs right after reset
      if ((spi.cclk !== 1'b0) || (spi.clatch_n !== 1'b1) || (spi.cdata !== 1'b0) ||
          (init_done !== 1'b0) || (busy !== 1'b0) || (host_ready !== 1'b0)) begin
         $display("[ERROR] %0t: after reset pins %b, init_done %b, busy %b, host_ready %b",
                  $time, spi, init_done, busy, host_ready);
         error_count++;
         report_test(1, "reset state", 1'b0);
      end else begin
         report_test(1, "reset state", 1'b1);
      end

      @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;

      // the host writes go in table order and the first one is offered before init is done
      for (int i = 0; i < HOST_LEN; i++) begin
         if (!HOST_STEPS[i].early && !HOST_STEPS[i].burst) begin
            host_valid = 1'b0;
            repeat (($urandom % 8) + 1) @(posedge clk);
            #1;
         end
         send_host(HOST_STEPS[i].cmd, HOST_STEPS[i].burst);
         if (i == 0) begin
            first_done = accept_done;
         end
      end
      host_valid = 1'b0;

      wait_words(INIT_LEN, "the init table words");
      if (!first_done) begin
         $display("the first host write was taken before init_done rose");
      end
      report_test(2, "init table", (init_errors == 0) && first_done);

      wait_words(TOTAL_LEN, "the host words");
      if (!held_seen) begin
         $display("the early host write was never held off");
      end
      report_test(3, "host writes", (host_errors == 0) && held_seen && first_done);
      if (!stall_seen) begin
         $display("host_ready never dropped during the host burst");
      end
      report_test(4, "host burst", (host_errors == 0) && stall_seen);

      // busy has to fall once the last transfer has finished
      cycles = 0;
      while (busy && (cycles < 4 * WORD_CYCLES)) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (busy) begin
         stop_on_timeout("busy to fall");
      end
      report_test(5, "cclk and latch timing", (timing_errors == 0) && (rx_count == TOTAL_LEN));

      // a second start must not replay the table
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      repeat (2 * WORD_CYCLES) begin
         @(posedge clk);
         #1;
         if (busy) begin
            busy_seen = 1'b1;
         end
      end
      if (busy_seen || (rx_count != TOTAL_LEN) || !init_done) begin
         $display("[ERROR] %0t: after second start busy seen %b, words %0d, init_done %b",
                  $time, busy_seen, rx_count, init_done);
         error_count++;
         report_test(6, "quiet after second start", 1'b0);
      end else begin
         report_test(6, "quiet after second start", 1'b1);
      end

      $display("tests run: 6, tests failed: %0d, check errors: %0d", failed_tests, error_count);
      if ((failed_tests == 0) && (error_count == 0)) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
codec_word_pkg.sv
spi_link_pkg.sv
codec_init_sequencer.sv
cmd_fifo.sv
spi_ctrl_master.sv
codec_ctrl_top.sv
spi_slave_model.sv
tb_codec_ctrl.sv
